/* design/clockGatePkg.sv */
// Divisor and delays are 4 bits wide; the status state field assumes a 3-bit FSM encoding
`default_nettype none

package clockGatePkg;

    // Half-period length in master cycles, zero never stored
    typedef logic [3:0] divisor_t;

    // Up and down delays, counted in slow-clock periods
    typedef logic [3:0] delay_t;

    // Wishbone word address and data
    typedef logic [1:0]  wbAddr_t;
    typedef logic [31:0] wbData_t;

    // Sequencer FSM, OFF must stay at zero so status reads zero after reset
    typedef enum logic [2:0] {
        OFF,
        RAMP_UP,
        ACK_WAIT,
        ON,
        RAMP_DOWN
    } seqState_t;

    // Register block to divider and sequencer
    typedef struct packed {
        divisor_t divisor;
        delay_t   upDelay;
        delay_t   downDelay;
    } gateConfig_t;

    // Sequencer back to register block
    typedef struct packed {
        logic      clockOn;
        logic      clockAck;
        seqState_t state;
    } gateStatus_t;

    // Register map
    localparam wbAddr_t ADDR_DIVISOR = 2'd0;
    localparam wbAddr_t ADDR_DELAYS  = 2'd1;
    localparam wbAddr_t ADDR_STATUS  = 2'd2;

    // Reset defaults
    localparam divisor_t RESET_DIVISOR    = 4'd8;
    localparam delay_t   RESET_UP_DELAY   = 4'd2;
    localparam delay_t   RESET_DOWN_DELAY = 4'd8;

endpackage

`default_nettype wire

/* design/clockDivider.sv */
// New divisor applies at the next period boundary; gated clock shares it, so no glitch-free switch
`default_nettype none
`timescale 1ns/100ps

module clockDivider (
    input  wire logic                      clock,
    input  wire logic                      reset_b,
    input  wire clockGatePkg::gateConfig_t gateConfig,
    input  wire logic                      clockOn,
    output logic                           slowClock,
    output logic                           periodTick,
    output logic                           gatedClock
);

    // Divisor in use for the current period
    clockGatePkg::divisor_t activeDivisor;
    // Last count of the low phase
    clockGatePkg::divisor_t lowLimit;

    // Free-running counter pair
    clockGatePkg::divisor_t highCount;
    clockGatePkg::divisor_t lowCount;

    // Gated counter pair
    clockGatePkg::divisor_t gatedHighCount;
    clockGatePkg::divisor_t gatedLowCount;

    assign lowLimit = activeDivisor - clockGatePkg::divisor_t'(1);

    // Free-running slow clock
    // High phase first, then low phase, then reload
    always_ff @(posedge clock or negedge reset_b)
    begin
        if (!reset_b)
        begin
            highCount     <= '0;
            lowCount      <= '0;
            slowClock     <= 1'b0;
            periodTick    <= 1'b0;
            activeDivisor <= clockGatePkg::RESET_DIVISOR;
        end
        else if (highCount < activeDivisor)
        begin
            highCount  <= highCount + 1'b1;
            slowClock  <= 1'b1;
            // Tick only in the cycle the slow clock rises
            periodTick <= (highCount == '0);
        end
        else if (lowCount < lowLimit)
        begin
            lowCount   <= lowCount + 1'b1;
            slowClock  <= 1'b0;
            periodTick <= 1'b0;
        end
        else
        begin
            // Period boundary, pick up a new divisor here
            highCount     <= '0;
            lowCount      <= '0;
            slowClock     <= 1'b0;
            periodTick    <= 1'b0;
            activeDivisor <= gateConfig.divisor;
        end
    end

    // Gated copy of the same waveform
    // Counters held clear while off, so it restarts from zero
    always_ff @(posedge clock or negedge reset_b)
    begin
        if (!reset_b)
        begin
            gatedHighCount <= '0;
            gatedLowCount  <= '0;
            gatedClock     <= 1'b0;
        end
        else if (!clockOn)
        begin
            gatedHighCount <= '0;
            gatedLowCount  <= '0;
            gatedClock     <= 1'b0;
        end
        else if (gatedHighCount < activeDivisor)
        begin
            gatedHighCount <= gatedHighCount + 1'b1;
            gatedClock     <= 1'b1;
        end
        else if (gatedLowCount < lowLimit)
        begin
            gatedLowCount <= gatedLowCount + 1'b1;
            gatedClock    <= 1'b0;
        end
        else
        begin
            gatedHighCount <= '0;
            gatedLowCount  <= '0;
            gatedClock     <= 1'b0;
        end
    end

    // Gated clock parked low once the sequencer has dropped clockOn
    gatedLowWhenOff: assert property (@(posedge clock) disable iff (!reset_b)
        (!clockOn && $past(!clockOn)) |-> !gatedClock);

endmodule

`default_nettype wire

/* design/gateSequencer.sv */
// Advances only on periodTick; a zero up or down delay behaves as the shortest ramp possible
`default_nettype none
`timescale 1ns/100ps

module gateSequencer (
    input  wire logic                      clock,
    input  wire logic                      reset_b,
    input  wire clockGatePkg::gateConfig_t gateConfig,
    input  wire logic                      periodTick,
    input  wire logic                      clockRequest,
    output logic                           clockOn,
    output logic                           clockAck,
    output clockGatePkg::gateStatus_t      status
);

    clockGatePkg::seqState_t state;

    // One counter serves both ramps
    clockGatePkg::delay_t delayCount;
    clockGatePkg::delay_t nextCount;

    assign nextCount = delayCount + clockGatePkg::delay_t'(1);

    always_ff @(posedge clock or negedge reset_b)
    begin
        if (!reset_b)
        begin
            state      <= clockGatePkg::OFF;
            delayCount <= '0;
            clockOn    <= 1'b0;
            clockAck   <= 1'b0;
        end
        else if (periodTick)
        begin
            case (state)
                clockGatePkg::OFF:
                begin
                    // First tick after the request counts as one period
                    if (clockRequest)
                    begin
                        if (gateConfig.upDelay <= clockGatePkg::delay_t'(1))
                        begin
                            clockOn <= 1'b1;
                            state   <= clockGatePkg::ACK_WAIT;
                        end
                        else
                        begin
                            delayCount <= clockGatePkg::delay_t'(1);
                            state      <= clockGatePkg::RAMP_UP;
                        end
                    end
                end
                clockGatePkg::RAMP_UP:
                begin
                    // Request withdrawn, ramp down with no ack
                    if (!clockRequest)
                    begin
                        delayCount <= '0;
                        state      <= clockGatePkg::RAMP_DOWN;
                    end
                    else if (nextCount >= gateConfig.upDelay)
                    begin
                        clockOn <= 1'b1;
                        state   <= clockGatePkg::ACK_WAIT;
                    end
                    else
                        delayCount <= nextCount;
                end
                clockGatePkg::ACK_WAIT, clockGatePkg::ON:
                begin
                    if (!clockRequest)
                    begin
                        // Ack drops on this tick
                        clockAck <= 1'b0;
                        if (gateConfig.downDelay == '0)
                        begin
                            clockOn <= 1'b0;
                            state   <= clockGatePkg::OFF;
                        end
                        else
                        begin
                            delayCount <= '0;
                            state      <= clockGatePkg::RAMP_DOWN;
                        end
                    end
                    else if (state == clockGatePkg::ACK_WAIT)
                    begin
                        // Clock has run one period, now acknowledge
                        clockAck <= 1'b1;
                        state    <= clockGatePkg::ON;
                    end
                end
                clockGatePkg::RAMP_DOWN:
                begin
                    // Compare with >= in case the delay shrinks mid-ramp
                    if (nextCount >= gateConfig.downDelay)
                    begin
                        clockOn    <= 1'b0;
                        delayCount <= '0;
                        state      <= clockGatePkg::OFF;
                    end
                    else
                        delayCount <= nextCount;
                end
                default:
                    state <= clockGatePkg::OFF;
            endcase
        end
    end

    assign status = '{clockOn: clockOn, clockAck: clockAck, state: state};

    // Ack only while the gated clock is running
    ackNeedsClock: assert property (@(posedge clock) disable iff (!reset_b)
        clockAck |-> clockOn);

    // Clock only switched on by a live request
    onNeedsRequest: assert property (@(posedge clock) disable iff (!reset_b)
        $rose(clockOn) |-> $past(clockRequest));

endmodule

`default_nettype wire

/* design/configRegisters.sv */
// Wishbone classic only, no wait states or error ack; only wbSel[0] qualifies a write
`default_nettype none
`timescale 1ns/100ps

module configRegisters #(
    parameter int unsigned DIVISOR_FLOOR = 1
) (
    input  wire logic                      clock,
    input  wire logic                      reset_b,
    input  wire logic                      wbCyc,
    input  wire logic                      wbStb,
    input  wire logic                      wbWe,
    input  wire clockGatePkg::wbAddr_t     wbAddr,
    input  wire clockGatePkg::wbData_t     wbDataIn,
    input  wire logic [3:0]                wbSel,
    input  wire clockGatePkg::gateStatus_t status,
    output logic                           wbAck,
    output clockGatePkg::wbData_t          wbDataOut,
    output clockGatePkg::gateConfig_t      gateConfig
);

    // Clamp value at register width
    localparam clockGatePkg::divisor_t FLOOR = clockGatePkg::divisor_t'(DIVISOR_FLOOR);

    // Accepted access, the ack guard keeps it to one cycle
    logic access;
    logic writeEnable;
    clockGatePkg::divisor_t newDivisor;
    clockGatePkg::wbData_t  readWord;

    assign access      = wbCyc && wbStb && !wbAck;
    assign writeEnable = access && wbWe && wbSel[0];
    assign newDivisor  = wbDataIn[3:0];

    // Ack and register writes on the same edge
    always_ff @(posedge clock or negedge reset_b)
    begin
        if (!reset_b)
        begin
            wbAck      <= 1'b0;
            gateConfig <= '{divisor:   clockGatePkg::RESET_DIVISOR,
                            upDelay:   clockGatePkg::RESET_UP_DELAY,
                            downDelay: clockGatePkg::RESET_DOWN_DELAY};
        end
        else
        begin
            wbAck <= access;
            if (writeEnable)
            begin
                case (wbAddr)
                    clockGatePkg::ADDR_DIVISOR:
                        gateConfig.divisor <= (newDivisor < FLOOR) ? FLOOR : newDivisor;
                    clockGatePkg::ADDR_DELAYS:
                    begin
                        gateConfig.upDelay   <= wbDataIn[3:0];
                        gateConfig.downDelay <= wbDataIn[7:4];
                    end
                    // Status and unmapped addresses drop the write
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // Read mux
    always_comb
    begin
        case (wbAddr)
            clockGatePkg::ADDR_DIVISOR:
                readWord = {28'd0, gateConfig.divisor};
            clockGatePkg::ADDR_DELAYS:
                readWord = {24'd0, gateConfig.downDelay, gateConfig.upDelay};
            clockGatePkg::ADDR_STATUS:
                readWord = {27'd0, status.state, status.clockAck, status.clockOn};
            default:
                readWord = '0;
        endcase
    end

    // Read data, valid alongside wbAck
    always_ff @(posedge clock)
    begin
        if (access && !wbWe)
            wbDataOut <= readWord;
    end

    // One-cycle ack per access
    ackSingleCycle: assert property (@(posedge clock) disable iff (!reset_b)
        wbAck |=> !wbAck);

    // Divisor never drops below the floor
    divisorAtFloor: assert property (@(posedge clock) disable iff (!reset_b)
        gateConfig.divisor >= FLOOR);

endmodule

`default_nettype wire

/* design/clockGateTop.sv */
// Single clock domain; slowClock and gatedClock are outputs only and clock no logic inside
`default_nettype none
`timescale 1ns/100ps

module clockGateTop #(
    parameter int unsigned DIVISOR_FLOOR = 1
) (
    input  wire logic                  clock,
    input  wire logic                  reset_b,
    // Wishbone classic slave
    input  wire logic                  wbCyc,
    input  wire logic                  wbStb,
    input  wire logic                  wbWe,
    input  wire clockGatePkg::wbAddr_t wbAddr,
    input  wire clockGatePkg::wbData_t wbDataIn,
    input  wire logic [3:0]            wbSel,
    output logic                       wbAck,
    output clockGatePkg::wbData_t      wbDataOut,
    // Four-phase clock request
    input  wire logic                  clockRequest,
    output logic                       clockAck,
    // Divided clocks
    output logic                       slowClock,
    output logic                       gatedClock
);

    clockGatePkg::gateConfig_t gateConfig;
    clockGatePkg::gateStatus_t gateStatus;
    logic periodTick;
    logic clockOn;

    // Registers, floor passed down
    configRegisters #(
        .DIVISOR_FLOOR(DIVISOR_FLOOR)
    ) registers (
        .clock      (clock),
        .reset_b    (reset_b),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAddr     (wbAddr),
        .wbDataIn   (wbDataIn),
        .wbSel      (wbSel),
        .status     (gateStatus),
        .wbAck      (wbAck),
        .wbDataOut  (wbDataOut),
        .gateConfig (gateConfig)
    );

    clockDivider divider (
        .clock      (clock),
        .reset_b    (reset_b),
        .gateConfig (gateConfig),
        .clockOn    (clockOn),
        .slowClock  (slowClock),
        .periodTick (periodTick),
        .gatedClock (gatedClock)
    );

    // Handshake paced by the divider tick
    gateSequencer sequencer (
        .clock        (clock),
        .reset_b      (reset_b),
        .gateConfig   (gateConfig),
        .periodTick   (periodTick),
        .clockRequest (clockRequest),
        .clockOn      (clockOn),
        .clockAck     (clockAck),
        .status       (gateStatus)
    );

endmodule

`default_nettype wire

/* bench/benchBusTasks.svh */
// Included inside clockGateBench; relies on its bus signals and on stepCycle for the falling edge
`ifndef BENCH_BUS_TASKS_SVH
`define BENCH_BUS_TASKS_SVH

// Per-test and overall bookkeeping
string testName;
int    testErrors;
int    totalErrors;
int    testsRun;
int    testsFailed;

// Compare one value against its expected form
task automatic checkValue(input string what, input clockGatePkg::wbData_t expected,
                          input clockGatePkg::wbData_t actual);
    assert (expected == actual)
    else
    begin
        $display("mismatch %s %s expected %0d actual %0d", testName, what, expected, actual);
        testErrors++;
    end
endtask

// Single write with the ack expected on the next edge
task automatic wbWrite(input clockGatePkg::wbAddr_t addr, input clockGatePkg::wbData_t data);
    wbCyc    = 1'b1;
    wbStb    = 1'b1;
    wbWe     = 1'b1;
    wbAddr   = addr;
    wbDataIn = data;
    wbSel    = 4'hf;
    stepCycle();
    assert (wbAck)
    else
    begin
        $display("%s: write to address %0d got no ack after one cycle", testName, addr);
        testErrors++;
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
    // Strobe stays low for a cycle before the next access
    stepCycle();
endtask

// Single read with data taken while ack is high
task automatic wbRead(input clockGatePkg::wbAddr_t addr, output clockGatePkg::wbData_t data);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b0;
    wbAddr = addr;
    stepCycle();
    assert (wbAck)
    else
    begin
        $display("%s: read of address %0d got no ack after one cycle", testName, addr);
        testErrors++;
    end
    data  = wbDataOut;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    // Strobe stays low for a cycle before the next access
    stepCycle();
endtask

// One line per finished test
task automatic closeTest;
    testsRun++;
    if (testErrors != 0)
        testsFailed++;
    $display("test %s: %s with %0d errors", testName, (testErrors == 0) ? "ok" : "bad",
             testErrors);
    totalErrors += testErrors;
    testErrors = 0;
endtask

`endif

/* bench/clockGateBench.sv */
// Divisors 2..15 in handshake tests so gated and slow edges never share a sample point
`default_nettype none
`timescale 1ns/100ps

module clockGateBench;

    // Six tests at worst case 16 + 2*15*(15+15+2) cycles each, rounded up
    localparam int TIMEOUT_CYCLES = 6000;
    // ON is the fourth sequencer state
    localparam int STATE_ON = 3;

    logic clock;
    logic reset_b;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    clockGatePkg::wbAddr_t wbAddr;
    clockGatePkg::wbData_t wbDataIn;
    logic [3:0] wbSel;
    logic wbAck;
    clockGatePkg::wbData_t wbDataOut;
    logic clockRequest;
    logic clockAck;
    logic slowClock;
    logic gatedClock;

    // Edge tracking at the falling edge
    logic prevSlow;
    logic prevGated;
    logic prevAck;
    logic slowRose;
    logic gatedRose;
    logic ackRose;
    logic ackFell;
    // High while a cancelled request must stay silent
    logic cancelWatch;
    int   cycleCount;

    clockGateTop u_dut (
        .clock        (clock),
        .reset_b      (reset_b),
        .wbCyc        (wbCyc),
        .wbStb        (wbStb),
        .wbWe         (wbWe),
        .wbAddr       (wbAddr),
        .wbDataIn     (wbDataIn),
        .wbSel        (wbSel),
        .wbAck        (wbAck),
        .wbDataOut    (wbDataOut),
        .clockRequest (clockRequest),
        .clockAck     (clockAck),
        .slowClock    (slowClock),
        .gatedClock   (gatedClock)
    );

    `include "benchBusTasks.svh"

    initial
    begin
        clock = 1'b0;
    end

    always #50 clock = ~clock;

    // Run limit
    always @(posedge clock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles in test %s", cycleCount, testName);
            $display("tests failed");
            $finish;
        end
    end

    // Bus ack lasts one cycle
    ackOneCycle: assert property (@(posedge clock) disable iff (!reset_b)
        wbAck |=> !wbAck)
    else
    begin
        $display("%s: wbAck stayed high for two cycles", testName);
        testErrors++;
    end

    // Ack only answers a strobe
    ackAnswersStrobe: assert property (@(posedge clock) disable iff (!reset_b)
        wbAck |-> $past(wbCyc && wbStb))
    else
    begin
        $display("%s: wbAck without a preceding strobe", testName);
        testErrors++;
    end

    ackNeedsRequest: assert property (@(posedge clock) disable iff (!reset_b)
        $rose(clockAck) |-> clockRequest)
    else
    begin
        $display("%s: clockAck rose with no request", testName);
        testErrors++;
    end

    cancelQuiet: assert property (@(posedge clock) disable iff (!reset_b)
        cancelWatch |-> (!clockAck && !gatedClock))
    else
    begin
        $display("%s: cancelled request produced ack or gated clock", testName);
        testErrors++;
    end

    task automatic stepCycle;
        @(negedge clock);
        slowRose  = slowClock && !prevSlow;
        gatedRose = gatedClock && !prevGated;
        ackRose   = clockAck && !prevAck;
        ackFell   = !clockAck && prevAck;
        prevSlow  = slowClock;
        prevGated = gatedClock;
        prevAck   = clockAck;
    endtask

    task automatic waitSlowLow;
        stepCycle();
        while (slowClock)
            stepCycle();
    endtask

    // High and low phase lengths after skipping some rises
    task automatic measureWave(input bit useGated, input int skip, output int high,
                               output int low);
        int seen;
        seen = 0;
        while (seen < skip)
        begin
            stepCycle();
            if (useGated ? gatedRose : slowRose)
                seen++;
        end
        high = 1;
        stepCycle();
        while (useGated ? gatedClock : slowClock)
        begin
            high++;
            stepCycle();
        end
        low = 0;
        while (!(useGated ? gatedClock : slowClock))
        begin
            low++;
            stepCycle();
        end
    endtask

    function automatic clockGatePkg::wbData_t statusWord(input int on, input int ack,
                                                        input int state);
        return clockGatePkg::wbData_t'((state << 2) | (ack << 1) | on);
    endfunction

    initial
    begin
        clockGatePkg::wbData_t readData;
        int divisor;
        int upDelay;
        int downDelay;
        int high;
        int low;
        int rises;
        int firstGated;
        int ackAt;
        int lastGated;

        void'($urandom(32'hc75ce0a8));
        reset_b      = 1'b0;
        wbCyc        = 1'b0;
        wbStb        = 1'b0;
        wbWe         = 1'b0;
        wbAddr       = '0;
        wbDataIn     = '0;
        wbSel        = '0;
        clockRequest = 1'b0;
        cancelWatch  = 1'b0;
        cycleCount   = 0;
        prevSlow     = 1'b0;
        prevGated    = 1'b0;
        prevAck      = 1'b0;
        testName     = "reset";
        testErrors   = 0;
        totalErrors  = 0;
        testsRun     = 0;
        testsFailed  = 0;
        repeat (3) @(negedge clock);
        reset_b = 1'b1;

        // Reset values, readback, divisor clamp
        testName = "reset-readback";
        wbRead(clockGatePkg::ADDR_DIVISOR, readData);
        checkValue("divisor", 8, readData);
        wbRead(clockGatePkg::ADDR_DELAYS, readData);
        checkValue("delays", (8 << 4) | 2, readData);
        wbRead(clockGatePkg::ADDR_STATUS, readData);
        checkValue("status", 0, readData);
        wbWrite(clockGatePkg::ADDR_DIVISOR, 5);
        wbRead(clockGatePkg::ADDR_DIVISOR, readData);
        checkValue("divisor", 5, readData);
        wbWrite(clockGatePkg::ADDR_DIVISOR, 0);
        wbRead(clockGatePkg::ADDR_DIVISOR, readData);
        checkValue("clamped divisor", 1, readData);
        wbWrite(clockGatePkg::ADDR_DELAYS, 32'h3a);
        wbRead(clockGatePkg::ADDR_DELAYS, readData);
        checkValue("delays", 32'h3a, readData);
        wbWrite(clockGatePkg::ADDR_STATUS, 32'hff);
        wbRead(clockGatePkg::ADDR_STATUS, readData);
        checkValue("status after write", 0, readData);
        closeTest();

        testName = "free-running";
        repeat (3)
        begin
            divisor = int'($urandom_range(15, 1));
            wbWrite(clockGatePkg::ADDR_DIVISOR, divisor);
            // Second rise is surely from the new divisor
            measureWave(1'b0, 2, high, low);
            checkValue("high phase", divisor, high);
            checkValue("low phase", divisor, low);
        end
        closeTest();

        testName  = "power-up";
        divisor   = int'($urandom_range(15, 2));
        upDelay   = int'($urandom_range(15, 1));
        downDelay = int'($urandom_range(15, 1));
        wbWrite(clockGatePkg::ADDR_DIVISOR, divisor);
        wbWrite(clockGatePkg::ADDR_DELAYS, (downDelay << 4) | upDelay);
        measureWave(1'b0, 2, high, low);
        waitSlowLow();
        clockRequest = 1'b1;
        rises      = 0;
        firstGated = -1;
        ackAt      = -1;
        while (!clockAck)
        begin
            stepCycle();
            if (slowRose)
                rises++;
            if (gatedRose && firstGated < 0)
                firstGated = rises;
            if (ackRose)
                ackAt = rises;
        end
        checkValue("rises before gated clock", upDelay, firstGated);
        checkValue("rises before ack", upDelay + 1, ackAt);
        measureWave(1'b1, 1, high, low);
        checkValue("gated high phase", divisor, high);
        checkValue("gated low phase", divisor, low);
        closeTest();

        testName = "power-down";
        waitSlowLow();
        clockRequest = 1'b0;
        rises     = 0;
        ackAt     = -1;
        lastGated = 0;
        while (rises < downDelay + 3)
        begin
            stepCycle();
            if (slowRose)
                rises++;
            if (ackFell)
                ackAt = rises;
            if (gatedRose)
                lastGated = rises;
        end
        checkValue("rises before ack falls", 1, ackAt);
        checkValue("rise of last gated pulse", downDelay, lastGated);
        checkValue("gated clock parked", 0, gatedClock);
        closeTest();

        testName = "status";
        wbWrite(clockGatePkg::ADDR_DIVISOR, 2);
        wbWrite(clockGatePkg::ADDR_DELAYS, (1 << 4) | 1);
        waitSlowLow();
        clockRequest = 1'b1;
        while (!clockAck)
            stepCycle();
        wbRead(clockGatePkg::ADDR_STATUS, readData);
        checkValue("status while on", statusWord(1, 1, STATE_ON), readData);
        checkValue("status ack against pin", clockAck, readData[1]);
        clockRequest = 1'b0;
        rises = 0;
        while (rises < 4)
        begin
            stepCycle();
            if (slowRose)
                rises++;
        end
        wbRead(clockGatePkg::ADDR_STATUS, readData);
        checkValue("status while off", statusWord(0, 0, 0), readData);
        checkValue("status ack against pin", clockAck, readData[1]);
        closeTest();

        // Request withdrawn inside the up delay
        testName = "cancelled";
        wbWrite(clockGatePkg::ADDR_DELAYS, (2 << 4) | 6);
        waitSlowLow();
        clockRequest = 1'b1;
        cancelWatch  = 1'b1;
        rises = 0;
        while (rises < 2)
        begin
            stepCycle();
            if (slowRose)
                rises++;
        end
        clockRequest = 1'b0;
        while (rises < 12)
        begin
            stepCycle();
            if (slowRose)
                rises++;
        end
        cancelWatch = 1'b0;
        wbRead(clockGatePkg::ADDR_STATUS, readData);
        checkValue("status after cancel", 0, readData);
        closeTest();

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrors);
        if (testsFailed == 0 && totalErrors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
design/clockGatePkg.sv
design/clockDivider.sv
design/gateSequencer.sv
design/configRegisters.sv
design/clockGateTop.sv
bench/clockGateBench.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module clockGateBench -o clockGateSim &&
./obj_dir/clockGateSim | tee /dev/stderr | grep -qx "all tests passed" &&
echo "simulation passed" ||
{
    echo "simulation did not pass"
    exit 1
}
